// ==== all.f ====
src/mem_pkg.sv
src/d_cache.sv
src/aes_cmd_gen.sv
src/mem_wb_reg.sv
src/mem_stage.sv
test/bus_mem.sv
test/tb_mem_stage.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_mem_stage -o sim_mem_stage
./obj_dir/sim_mem_stage > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** FAILED ***' sim.log; then
	exit 1
fi
grep -qF '*** PASSED ***' sim.log

// ==== src/aes_cmd_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module aes_cmd_gen (
	input  wire                   aes_req_i,
	input  wire                   aes_load_i,
	input  wire mem_pkg::aes_op_e funct3_i,
	input  wire  [31:0]           alu_i,
	input  wire  [31:0]           rs2_i,
	output logic [31:0]           cmd_addr_o,
	output logic                  cmd_we_o,
	output logic [127:0]          cmd_wdata_o
);
	import mem_pkg::*;

	logic        is_dma;
	logic        to_mem;
	logic [31:0] buf_base;
	logic [7:0]  dma_len;
	logic [31:0] dma_cfg;
	logic [31:0] dma_src;
	logic [31:0] dma_dst;

	assign is_dma = funct3_i inside {aes_block, aes_key, aes_result};
	assign to_mem = (funct3_i == aes_result);

	always_comb begin
		case (funct3_i)
			aes_key:    buf_base = AES_BUF_KEY;
			aes_result: buf_base = AES_BUF_RESULT;
			default:    buf_base = AES_BUF_BLOCK;
		endcase
	end

	// length counts words, minus one, of rs2 blocks
	assign dma_len = (rs2_i[7:0] << 2) + 8'd3;

	always_comb begin
		dma_cfg = '0;
		dma_cfg[DMA_LEN_LSB +: 8]   = dma_len;
		dma_cfg[DMA_SIZE_LSB +: 3]  = 3'd2;
		dma_cfg[DMA_BURST_LSB +: 2] = 2'd1;
		dma_cfg[DMA_MODE_BIT]       = to_mem;
	end

	// result runs from the accelerator back to memory
	assign dma_src = to_mem ? buf_base : alu_i;
	assign dma_dst = to_mem ? alu_i : buf_base;

	always_comb begin
		case (funct3_i)
			aes_ctrl:   cmd_addr_o = AES_ADDR_CTRL;
			aes_confi:  cmd_addr_o = AES_ADDR_CONFIG;
			aes_start:  cmd_addr_o = AES_ADDR_START;
			aes_status: cmd_addr_o = AES_ADDR_STATUS;
			default:    cmd_addr_o = AES_ADDR_DESC;
		endcase
	end

	assign cmd_we_o    = aes_req_i && !aes_load_i;
	assign cmd_wdata_o = is_dma ? {32'd1, dma_cfg, dma_dst, dma_src} : {96'd0, alu_i};

	// decode only knows one AES load
	always_comb begin
		if (aes_req_i && aes_load_i) begin
			assert #0 (funct3_i == aes_status)
			else $error("AES load with opcode %0d", funct3_i);
		end
	end

endmodule

`default_nettype wire

// ==== src/d_cache.sv ====
`timescale 1ns/100ps
`default_nettype none

module d_cache (
	input  wire                           clk_i,
	input  wire                           rst_ni,
	input  wire                           req_valid_i,
	input  wire  [31:0]                   req_addr_i,
	input  wire  [31:0]                   req_wdata_i,
	input  wire                           req_we_i,
	output logic                          res_ready_o,
	output logic [31:0]                   res_rdata_o,
	output logic                          bus_req_o,
	output logic                          bus_we_o,
	output logic [31:0]                   bus_addr_o,
	output logic [mem_pkg::LINE_BITS-1:0] bus_wdata_o,
	input  wire  [mem_pkg::LINE_BITS-1:0] bus_rdata_i,
	input  wire                           bus_rvalid_i
);
	import mem_pkg::*;

	cache_state_e state_q;
	cache_state_e state_d;

	logic [TAG_W-1:0]      tag_q  [CACHE_SETS];
	logic [LINE_BITS-1:0]  line_q [CACHE_SETS];
	logic [CACHE_SETS-1:0] valid_q;
	logic [CACHE_SETS-1:0] dirty_q;

	logic [INDEX_W-1:0]   idx;
	logic [TAG_W-1:0]     tag;
	logic [1:0]           word_sel;
	logic [LINE_BITS-1:0] line;
	logic                 hit;
	logic                 fill;
	logic                 store_hit;

	assign idx      = req_addr_i[TAG_LSB-1:INDEX_LSB];
	assign tag      = req_addr_i[31:TAG_LSB];
	assign word_sel = req_addr_i[INDEX_LSB-1:2];
	assign line     = line_q[idx];
	assign hit      = valid_q[idx] && (tag_q[idx] == tag);

	assign res_ready_o = req_valid_i && hit && (state_q == st_idle);
	assign res_rdata_o = line[{word_sel, 5'b0} +: 32];

	assign fill      = (state_q == st_allocate) && bus_rvalid_i;
	assign store_hit = res_ready_o && req_we_i;

	// victim address in write back, requested line in allocate
	assign bus_req_o   = (state_q != st_idle);
	assign bus_we_o    = (state_q == st_write_back);
	assign bus_addr_o  = bus_we_o ? {tag_q[idx], idx, {INDEX_LSB{1'b0}}}
	                              : {tag, idx, {INDEX_LSB{1'b0}}};
	assign bus_wdata_o = line;

	always_comb begin
		state_d = state_q;
		case (state_q)
			st_idle: begin
				if (req_valid_i && !hit) begin
					if (valid_q[idx] && dirty_q[idx]) begin
						state_d = st_write_back;
					end else begin
						state_d = st_allocate;
					end
				end
			end
			st_write_back: begin
				if (bus_rvalid_i) begin
					state_d = st_allocate;
				end
			end
			st_allocate: begin
				// back to idle, the retried access then hits
				if (bus_rvalid_i) begin
					state_d = st_idle;
				end
			end
			default: state_d = st_idle;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q <= st_idle;
			valid_q <= '0;
			dirty_q <= '0;
		end else begin
			state_q <= state_d;
			if (fill) begin
				valid_q[idx] <= 1'b1;
				dirty_q[idx] <= 1'b0;
			end else if (store_hit) begin
				dirty_q[idx] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (fill) begin
			line_q[idx] <= bus_rdata_i;
			tag_q[idx]  <= tag;
		end else if (store_hit) begin
			// merge the stored word into the line
			line_q[idx][{word_sel, 5'b0} +: 32] <= req_wdata_i;
		end
	end

	// a line transfer keeps its request steady until the memory answers
	assert property (@(posedge clk_i) disable iff (!rst_ni)
		bus_req_o && !bus_rvalid_i |=> bus_req_o && $stable(bus_addr_o) && $stable(bus_we_o));

	// a refilled line answers the retried access
	assert property (@(posedge clk_i) disable iff (!rst_ni)
		fill |=> !req_valid_i || res_ready_o);

endmodule

`default_nettype wire

// ==== src/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

	// funct3 of the custom AES instructions
	typedef enum logic [2:0] {
		aes_ctrl   = 3'd0,
		aes_confi  = 3'd1,
		aes_block  = 3'd2,
		aes_key    = 3'd3,
		aes_result = 3'd4,
		aes_start  = 3'd5,
		aes_status = 3'd6
	} aes_op_e;

	typedef enum logic [1:0] {
		st_idle,
		st_write_back,
		st_allocate
	} cache_state_e;

	// accelerator registers, everything below AES_ADDR_CTRL is cacheable
	localparam logic [31:0] AES_ADDR_CTRL   = 32'h1000_0000;
	localparam logic [31:0] AES_ADDR_CONFIG = 32'h1000_0010;
	localparam logic [31:0] AES_ADDR_DESC   = 32'h1000_0020;
	localparam logic [31:0] AES_ADDR_START  = 32'h1000_0030;
	localparam logic [31:0] AES_ADDR_STATUS = 32'h1000_0040;

	// accelerator buffers
	localparam logic [31:0] AES_BUF_BLOCK  = 32'h1000_1000;
	localparam logic [31:0] AES_BUF_KEY    = 32'h1000_2000;
	localparam logic [31:0] AES_BUF_RESULT = 32'h1000_3000;

	// dma config word
	localparam int DMA_LEN_LSB   = 0;
	localparam int DMA_SIZE_LSB  = 8;
	localparam int DMA_BURST_LSB = 11;
	localparam int DMA_MODE_BIT  = 13;

	// cache geometry
	localparam int CACHE_SETS = 16;
	localparam int LINE_BITS  = 128;
	localparam int TAG_LSB    = 8;
	localparam int INDEX_LSB  = 4;
	localparam int INDEX_W    = TAG_LSB - INDEX_LSB;
	localparam int TAG_W      = 32 - TAG_LSB;

endpackage

`default_nettype wire

// ==== src/mem_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_stage (
	input  wire          clk_i,
	input  wire          rst_ni,
	input  wire          enable_i,
	input  wire          flush_i,
	input  wire  [31:0]  alu_i,
	input  wire  [31:0]  rs2_i,
	input  wire  [31:0]  pc4_i,
	input  wire  [31:0]  inst_i,
	input  wire  [31:0]  csr_waddr_i,
	input  wire  [31:0]  csr_rdata_i,
	input  wire          mem_we_i,
	input  wire  [1:0]   wb_sel_i,
	input  wire          reg_we_i,
	input  wire  [4:0]   rd_i,
	input  wire          csr_we_i,
	input  wire          cache_req_i,
	input  wire          aes_req_i,
	input  wire          aes_load_i,
	input  wire  [127:0] mem_rdata_i,
	input  wire          mem_rvalid_i,
	output logic [31:0]  alu_wb_o,
	output logic [31:0]  pc4_wb_o,
	output logic [31:0]  mem_wb_o,
	output logic [31:0]  inst_wb_o,
	output logic [31:0]  csr_waddr_wb_o,
	output logic [31:0]  csr_rdata_wb_o,
	output logic [1:0]   wb_sel_wb_o,
	output logic         reg_we_wb_o,
	output logic [4:0]   rd_wb_o,
	output logic         csr_we_wb_o,
	output logic         stall_by_dcache_o,
	output logic         stall_by_aes_o,
	output logic         cs_o,
	output logic         we_o,
	output logic [31:0]  addr_o,
	output logic [127:0] wdata_o
);
	import mem_pkg::*;

	logic         cache_ready;
	logic [31:0]  cache_rdata;
	logic         cache_bus_req;
	logic         cache_bus_we;
	logic [31:0]  cache_bus_addr;
	logic [127:0] cache_bus_wdata;
	logic [31:0]  cmd_addr;
	logic         cmd_we;
	logic [127:0] cmd_wdata;
	logic         aes_cs;
	logic         capture;

	d_cache d_cache_i (
		.clk_i       (clk_i),
		.rst_ni      (rst_ni),
		.req_valid_i (cache_req_i),
		.req_addr_i  (alu_i),
		.req_wdata_i (rs2_i),
		.req_we_i    (mem_we_i),
		.res_ready_o (cache_ready),
		.res_rdata_o (cache_rdata),
		.bus_req_o   (cache_bus_req),
		.bus_we_o    (cache_bus_we),
		.bus_addr_o  (cache_bus_addr),
		.bus_wdata_o (cache_bus_wdata),
		.bus_rdata_i (mem_rdata_i),
		.bus_rvalid_i(mem_rvalid_i)
	);

	aes_cmd_gen aes_cmd_gen_i (
		.aes_req_i  (aes_req_i),
		.aes_load_i (aes_load_i),
		.funct3_i   (aes_op_e'(inst_i[14:12])),
		.alu_i      (alu_i),
		.rs2_i      (rs2_i),
		.cmd_addr_o (cmd_addr),
		.cmd_we_o   (cmd_we),
		.cmd_wdata_o(cmd_wdata)
	);

	// a held write would repeat while the stage is frozen
	assign aes_cs = aes_req_i && (aes_load_i || enable_i);

	// cache line transfers win the bus
	assign cs_o    = cache_bus_req || aes_cs;
	assign we_o    = cache_bus_req ? cache_bus_we : (aes_cs && cmd_we);
	assign addr_o  = cache_bus_req ? cache_bus_addr : cmd_addr;
	assign wdata_o = cache_bus_req ? cache_bus_wdata : cmd_wdata;

	assign stall_by_dcache_o = cache_req_i && !cache_ready;
	assign stall_by_aes_o    = aes_req_i && aes_load_i && !mem_rvalid_i;
	assign capture           = enable_i && !stall_by_dcache_o && !stall_by_aes_o;

	mem_wb_reg mem_wb_reg_i (
		.clk_i         (clk_i),
		.rst_ni        (rst_ni),
		.capture_i     (capture),
		.flush_i       (flush_i),
		.alu_i         (alu_i),
		.pc4_i         (pc4_i),
		.inst_i        (inst_i),
		.csr_waddr_i   (csr_waddr_i),
		.csr_rdata_i   (csr_rdata_i),
		.wb_sel_i      (wb_sel_i),
		.reg_we_i      (reg_we_i),
		.rd_i          (rd_i),
		.csr_we_i      (csr_we_i),
		.load_data_i   (cache_rdata),
		.status_i      (mem_rdata_i[31:0]),
		.aes_load_i    (aes_load_i),
		.alu_wb_o      (alu_wb_o),
		.pc4_wb_o      (pc4_wb_o),
		.mem_wb_o      (mem_wb_o),
		.inst_wb_o     (inst_wb_o),
		.csr_waddr_wb_o(csr_waddr_wb_o),
		.csr_rdata_wb_o(csr_rdata_wb_o),
		.wb_sel_wb_o   (wb_sel_wb_o),
		.reg_we_wb_o   (reg_we_wb_o),
		.rd_wb_o       (rd_wb_o),
		.csr_we_wb_o   (csr_we_wb_o)
	);

	// the bus mux relies on the two request sources never meeting
	assert property (@(posedge clk_i) disable iff (!rst_ni) !(cache_req_i && aes_req_i));

endmodule

`default_nettype wire

// ==== src/mem_wb_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_wb_reg (
	input  wire         clk_i,
	input  wire         rst_ni,
	input  wire         capture_i,
	input  wire         flush_i,
	input  wire  [31:0] alu_i,
	input  wire  [31:0] pc4_i,
	input  wire  [31:0] inst_i,
	input  wire  [31:0] csr_waddr_i,
	input  wire  [31:0] csr_rdata_i,
	input  wire  [1:0]  wb_sel_i,
	input  wire         reg_we_i,
	input  wire  [4:0]  rd_i,
	input  wire         csr_we_i,
	input  wire  [31:0] load_data_i,
	input  wire  [31:0] status_i,
	input  wire         aes_load_i,
	output logic [31:0] alu_wb_o,
	output logic [31:0] pc4_wb_o,
	output logic [31:0] mem_wb_o,
	output logic [31:0] inst_wb_o,
	output logic [31:0] csr_waddr_wb_o,
	output logic [31:0] csr_rdata_wb_o,
	output logic [1:0]  wb_sel_wb_o,
	output logic        reg_we_wb_o,
	output logic [4:0]  rd_wb_o,
	output logic        csr_we_wb_o
);

	// write enables and select
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			wb_sel_wb_o <= '0;
			reg_we_wb_o <= 1'b0;
			csr_we_wb_o <= 1'b0;
		end else if (capture_i) begin
			wb_sel_wb_o <= flush_i ? 2'b0 : wb_sel_i;
			reg_we_wb_o <= !flush_i && reg_we_i;
			csr_we_wb_o <= !flush_i && csr_we_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (capture_i) begin
			if (flush_i) begin
				alu_wb_o       <= '0;
				pc4_wb_o       <= '0;
				mem_wb_o       <= '0;
				inst_wb_o      <= '0;
				csr_waddr_wb_o <= '0;
				csr_rdata_wb_o <= '0;
				rd_wb_o        <= '0;
			end else begin
				alu_wb_o       <= alu_i;
				pc4_wb_o       <= pc4_i;
				// status word replaces the cache word
				mem_wb_o       <= aes_load_i ? status_i : load_data_i;
				inst_wb_o      <= inst_i;
				csr_waddr_wb_o <= csr_waddr_i;
				csr_rdata_wb_o <= csr_rdata_i;
				rd_wb_o        <= rd_i;
			end
		end
	end

endmodule

`default_nettype wire

// ==== test/bus_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

module bus_mem (
	input  wire          clk_i,
	input  wire          rst_ni,
	input  wire          cs_i,
	input  wire          we_i,
	input  wire  [31:0]  addr_i,
	input  wire  [127:0] wdata_i,
	output logic [127:0] rdata_o,
	output logic         rvalid_o
);
	import mem_pkg::*;

	localparam int LINES = 80;

	logic [127:0] mem_q [LINES];
	logic         busy_q;
	logic [1:0]   wait_q;
	logic [31:0]  status_q;
	logic         is_aes;
	int           aes_writes;

	assign is_aes = (addr_i >= AES_ADDR_CTRL);

	// every word depends on its full byte address
	initial begin
		for (int l = 0; l < LINES; l++) begin
			for (int w = 0; w < 4; w++) begin
				mem_q[l][w*32 +: 32] = (l * 16 + w * 4) * 32'h9e37_79b1 + 32'h6a09_e667;
			end
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			busy_q     <= 1'b0;
			wait_q     <= '0;
			rvalid_o   <= 1'b0;
			status_q   <= '0;
			aes_writes <= 0;
		end else begin
			rvalid_o <= 1'b0;
			if (cs_i && we_i && is_aes) begin
				// register writes are single pulses with no answer
				aes_writes <= aes_writes + 1;
			end else if (busy_q) begin
				if (wait_q == 2'd0) begin
					busy_q   <= 1'b0;
					rvalid_o <= 1'b1;
				end else begin
					wait_q <= wait_q - 2'd1;
				end
			end else if (cs_i && !rvalid_o) begin
				busy_q <= 1'b1;
				wait_q <= 2'($urandom_range(3, 0));
				if (is_aes) begin
					status_q <= $urandom;
				end
			end
		end
	end

	always @(posedge clk_i) begin
		if (busy_q && wait_q == 2'd0) begin
			if (is_aes) begin
				rdata_o <= {96'd0, status_q};
			end else if (we_i) begin
				mem_q[addr_i[10:4]] <= wdata_i;
			end else begin
				rdata_o <= mem_q[addr_i[10:4]];
			end
		end
	end

endmodule

`default_nettype wire

// ==== test/tb_mem_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_mem_stage;
	import mem_pkg::*;

	localparam int N_CACHE_OPS   = 300;
	localparam int N_AES_OPS     = 60;
	localparam int MAX_OPS       = 400;
	localparam int CYCLES_PER_OP = 12;
	localparam int WIN_WORDS     = 256;
	localparam int ALL_WORDS     = 320;

	logic         clk_i = 1'b0;
	logic         rst_ni;
	logic         enable_i;
	logic         flush_i;
	logic [31:0]  alu_i;
	logic [31:0]  rs2_i;
	logic [31:0]  pc4_i;
	logic [31:0]  inst_i;
	logic [31:0]  csr_waddr_i;
	logic [31:0]  csr_rdata_i;
	logic         mem_we_i;
	logic [1:0]   wb_sel_i;
	logic         reg_we_i;
	logic [4:0]   rd_i;
	logic         csr_we_i;
	logic         cache_req_i;
	logic         aes_req_i;
	logic         aes_load_i;
	logic [127:0] mem_rdata;
	logic         mem_rvalid;
	logic [31:0]  alu_wb_o;
	logic [31:0]  pc4_wb_o;
	logic [31:0]  mem_wb_o;
	logic [31:0]  inst_wb_o;
	logic [31:0]  csr_waddr_wb_o;
	logic [31:0]  csr_rdata_wb_o;
	logic [1:0]   wb_sel_wb_o;
	logic         reg_we_wb_o;
	logic [4:0]   rd_wb_o;
	logic         csr_we_wb_o;
	logic         stall_by_dcache_o;
	logic         stall_by_aes_o;
	logic         cs_o;
	logic         we_o;
	logic [31:0]  addr_o;
	logic [127:0] wdata_o;

	// flat word model of the cacheable window
	logic [31:0] model [ALL_WORDS];
	int          aes_write_count = 0;
	int          cycles = 0;

	mem_stage mem_stage_i (.*, .mem_rdata_i(mem_rdata), .mem_rvalid_i(mem_rvalid));

	bus_mem bus_mem_i (
		.clk_i   (clk_i),
		.rst_ni  (rst_ni),
		.cs_i    (cs_o),
		.we_i    (we_o),
		.addr_i  (addr_o),
		.wdata_i (wdata_o),
		.rdata_o (mem_rdata),
		.rvalid_o(mem_rvalid)
	);

	always #50 clk_i = ~clk_i;

	always @(posedge clk_i) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_OPS * CYCLES_PER_OP) begin
			$display("Timeout: the run did not finish within %0d cycles", cycles);
			$display("*** FAILED ***");
			$fatal(1, "timeout");
		end
	end

	task automatic check_eq(input logic [127:0] got, input logic [127:0] exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
			$display("*** FAILED ***");
			$fatal(1, "value check");
		end
	endtask

	// expected bus write of an AES instruction
	task automatic aes_expect(input logic [2:0] f3, input logic [31:0] alu, input logic [31:0] rs2,
		output logic [31:0] addr, output logic [127:0] data);
		logic [7:0]  len;
		logic [31:0] cfg;
		len  = rs2[7:0] * 8'd4 + 8'd3;
		cfg  = {18'd0, (aes_op_e'(f3) == aes_result), 2'd1, 3'd2, len};
		addr = AES_ADDR_DESC;
		case (aes_op_e'(f3))
			aes_ctrl: begin
				addr = AES_ADDR_CTRL;
				data = {96'd0, alu};
			end
			aes_confi: begin
				addr = AES_ADDR_CONFIG;
				data = {96'd0, alu};
			end
			aes_start: begin
				addr = AES_ADDR_START;
				data = {96'd0, alu};
			end
			aes_block: data = {32'd1, cfg, AES_BUF_BLOCK, alu};
			aes_key:   data = {32'd1, cfg, AES_BUF_KEY, alu};
			default:   data = {32'd1, cfg, alu, AES_BUF_RESULT};
		endcase
	endtask

	task automatic wait_accept();
		@(negedge clk_i);
		forever begin
			if (aes_load_i) begin
				check_eq(stall_by_aes_o, !mem_rvalid, "stall_by_aes_o");
			end
			if (!stall_by_dcache_o && !stall_by_aes_o) begin
				break;
			end
			@(negedge clk_i);
		end
	endtask

	task automatic run_op(input logic cache, input logic we, input logic aes, input logic load,
		input logic [2:0] f3, input logic [31:0] alu, input logic [31:0] rs2, input logic flush);
		logic [31:0]  exp_mem;
		logic [31:0]  exp_addr;
		logic [127:0] exp_data;
		int           w;
		w       = int'(alu[11:2]);
		exp_mem = '0;
		enable_i    <= 1'b1;
		flush_i     <= flush;
		cache_req_i <= cache;
		mem_we_i    <= we;
		aes_req_i   <= aes;
		aes_load_i  <= load;
		alu_i       <= alu;
		rs2_i       <= rs2;
		inst_i      <= {17'($urandom), f3, 12'($urandom)};
		pc4_i       <= $urandom;
		csr_waddr_i <= $urandom;
		csr_rdata_i <= $urandom;
		wb_sel_i    <= 2'($urandom);
		reg_we_i    <= 1'($urandom);
		rd_i        <= 5'($urandom);
		csr_we_i    <= 1'($urandom);
		wait_accept();
		if (aes && !load) begin
			aes_expect(f3, alu, rs2, exp_addr, exp_data);
			check_eq({cs_o, we_o}, 2'b11, "AES write strobes");
			check_eq(addr_o, exp_addr, "AES write address");
			check_eq(wdata_o, exp_data, "AES write data");
			aes_write_count++;
		end
		if (load) begin
			check_eq({cs_o, we_o, addr_o}, {2'b10, AES_ADDR_STATUS}, "AES status read request");
		end
		if (cache && we) begin
			model[w] = rs2;
		end else if (cache) begin
			exp_mem = model[w];
		end
		@(posedge clk_i);
		cache_req_i <= 1'b0;
		mem_we_i    <= 1'b0;
		aes_req_i   <= 1'b0;
		aes_load_i  <= 1'b0;
		flush_i     <= 1'b0;
		@(negedge clk_i);
		check_eq(cs_o, 1'b0, "cs_o after the access");
		if (flush) begin
			check_eq({alu_wb_o, pc4_wb_o, mem_wb_o, inst_wb_o}, '0, "flushed fields");
			check_eq({csr_waddr_wb_o, csr_rdata_wb_o, wb_sel_wb_o, reg_we_wb_o, rd_wb_o,
				csr_we_wb_o}, '0, "flushed controls");
		end else begin
			check_eq({alu_wb_o, pc4_wb_o, inst_wb_o, csr_waddr_wb_o},
				{alu_i, pc4_i, inst_i, csr_waddr_i}, "pass-through fields");
			check_eq({csr_rdata_wb_o, wb_sel_wb_o, reg_we_wb_o, rd_wb_o, csr_we_wb_o},
				{csr_rdata_i, wb_sel_i, reg_we_i, rd_i, csr_we_i}, "pass-through controls");
			if (cache && !we) begin
				check_eq(mem_wb_o, exp_mem, "load data");
			end
			if (load) begin
				check_eq(mem_wb_o, bus_mem_i.status_q, "AES status word");
			end
		end
		@(posedge clk_i);
	endtask

	initial begin
		logic [127:0] line;
		logic [2:0]   op;
		void'($urandom(32'h8c8e_a0e6));
		rst_ni      = 1'b0;
		enable_i    = 1'b0;
		flush_i     = 1'b0;
		alu_i       = '0;
		rs2_i       = '0;
		pc4_i       = '0;
		inst_i      = '0;
		csr_waddr_i = '0;
		csr_rdata_i = '0;
		mem_we_i    = 1'b0;
		wb_sel_i    = '0;
		reg_we_i    = 1'b0;
		rd_i        = '0;
		csr_we_i    = 1'b0;
		cache_req_i = 1'b0;
		aes_req_i   = 1'b0;
		aes_load_i  = 1'b0;
		repeat (3) @(posedge clk_i);
		rst_ni <= 1'b1;
		@(negedge clk_i);
		check_eq({cs_o, we_o, stall_by_dcache_o, stall_by_aes_o, reg_we_wb_o, csr_we_wb_o},
			'0, "outputs after reset");
		for (int w = 0; w < ALL_WORDS; w++) begin
			line     = bus_mem_i.mem_q[w / 4];
			model[w] = line[(w % 4) * 32 +: 32];
		end
		@(posedge clk_i);

		// 4 tags per set inside the window, so sets keep colliding
		for (int i = 0; i < N_CACHE_OPS; i++) begin
			run_op(1'b1, 1'($urandom), 1'b0, 1'b0, 3'($urandom),
				($urandom % WIN_WORDS) << 2, $urandom, 1'b0);
		end
		// loads outside the window push every dirty line out
		for (int s = 0; s < CACHE_SETS; s++) begin
			run_op(1'b1, 1'b0, 1'b0, 1'b0, 3'd0, 32'h400 + s * 16, '0, 1'b0);
		end
		for (int w = 0; w < WIN_WORDS; w++) begin
			line = bus_mem_i.mem_q[w / 4];
			check_eq(line[(w % 4) * 32 +: 32], model[w], "written back memory word");
		end

		for (int i = 0; i < N_AES_OPS; i++) begin
			op = 3'($urandom % 7);
			run_op(1'b0, 1'b0, 1'b1, (aes_op_e'(op) == aes_status), op, $urandom, $urandom, 1'b0);
		end
		repeat (4) begin
			run_op(1'b0, 1'b0, 1'b0, 1'b0, 3'($urandom), $urandom, $urandom, 1'b1);
		end
		check_eq(bus_mem_i.aes_writes, aes_write_count, "number of AES bus writes");

		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire
